/* sources.f */
hdl/mem_bus_pkg.sv
hdl/cache_geom_pkg.sv
hdl/cache_arrays.sv
hdl/cache_ctrl.sv
hdl/dcache_top.sv
test/word_memory.sv
test/dcache_tb.sv

/* Makefile */
# Verilator build for the data cache testbench

VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := dcache_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

# Static checks on RTL and testbench together
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; a failing check ends in $$fatal and a nonzero exit status
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* test/dcache_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_tb
    import mem_bus_pkg::*;
();

    localparam int          MEM_WORDS = 1024;
    localparam int          NUM_SETS  = 8;
    localparam int          TIMEOUT   = 20;    // Cycles per response wait
    localparam int          RAND_OPS  = 60;
    localparam logic [31:0] SEED      = 32'hf3e6;
    localparam addr_t       RAND_BASE = 12'h300;

    logic  CLK;
    logic  RSTn;
    logic  req;
    logic  req_store;
    addr_t req_addr;
    word_t req_wdata;
    logic  resp_valid;
    logic  resp_hit;
    word_t resp_rdata;
    addr_t mem_addr;
    logic  mem_we;
    word_t mem_wdata;
    word_t mem_rdata;

    // Reference model
    word_t                shadow [MEM_WORDS];
    logic [4:0]           tag_m  [NUM_SETS];
    logic [NUM_SETS-1:0]  valid_m;
    logic [31:0]          rng_state;

    dcache_top u_dut (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .req        (req),
        .req_store  (req_store),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_hit   (resp_hit),
        .resp_rdata (resp_rdata),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    word_memory u_mem (
        .CLK   (CLK),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;     // 100 ns period

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    // One request, its memory traffic and its response
    task automatic run_access(input addr_t a, input logic store, input word_t wdata);
        logic [4:0] tag;
        logic [2:0] idx;
        logic [1:0] wsel;
        logic [1:0] beat;
        logic       exp_hit;
        logic       exp_we;
        int         exp_lat;
        int         lat;
        int         k;
        word_t      exp_data;
        addr_t      exp_addr;

        tag      = a[11:7];
        idx      = a[6:4];
        wsel     = a[3:2];
        exp_hit  = valid_m[idx] && (tag_m[idx] == tag);
        exp_lat  = exp_hit ? 2 : 6;
        exp_data = shadow[a[11:2]];

        @(posedge CLK);
        #1;
        req       = 1'b1;
        req_store = store;
        req_addr  = a;
        req_wdata = wdata;
        @(posedge CLK);
        #1;
        req = 1'b0;

        lat = 0;
        for (k = 1; k <= TIMEOUT && lat == 0; k++) begin
            @(negedge CLK);    // Middle of cycle N+k
            beat     = 2'(k - 2);
            exp_we   = 1'b0;
            exp_addr = a;
            if (store && exp_hit && k == 1) begin
                exp_we = 1'b1;
            end
            if (!exp_hit && k >= 2 && k <= 5) begin
                exp_addr = {tag, idx, beat, 2'b00};    // Refill beat
                exp_we   = store && (beat == wsel);
                assert (mem_addr == exp_addr)
                    else abort_run($sformatf("Mismatch at %0t: refill address %h, expected %h",
                                             $time, mem_addr, exp_addr));
            end
            assert (mem_we == exp_we)
                else abort_run($sformatf("Mismatch at %0t: mem_we %b in cycle N+%0d, addr %h",
                                         $time, mem_we, k, a));
            if (exp_we) begin
                assert (mem_addr == exp_addr && mem_wdata == wdata)
                    else abort_run($sformatf("Mismatch at %0t: memory write %h <= %h",
                                             $time, mem_addr, mem_wdata));
            end
            if (resp_valid) begin
                lat = k;
            end
        end

        if (lat == 0) begin
            abort_run($sformatf("No response within %0d cycles for address %h", TIMEOUT, a));
        end
        assert (lat == exp_lat)
            else abort_run($sformatf("Mismatch at %0t: latency %0d, expected %0d for %h",
                                     $time, lat, exp_lat, a));
        assert (resp_hit == exp_hit)
            else abort_run($sformatf("Mismatch at %0t: resp_hit %b, expected %b for %h",
                                     $time, resp_hit, exp_hit, a));
        if (!store) begin
            assert (resp_rdata == exp_data)
                else abort_run($sformatf("Mismatch at %0t: load %h returned %h, expected %h",
                                         $time, a, resp_rdata, exp_data));
        end

        // Write-through keeps memory and line in step
        if (store) begin
            shadow[a[11:2]] = wdata;
        end
        if (!exp_hit) begin
            tag_m[idx]   = tag;
            valid_m[idx] = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int    i;
        addr_t r_addr;
        logic  r_store;

        req       = 1'b0;
        req_store = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        RSTn      = 1'b1;
        valid_m   = '0;

        rng_state = SEED;
        for (i = 0; i < MEM_WORDS; i++) begin
            rng_state    = lcg_next(rng_state);
            u_mem.mem[i] = rng_state ^ word_t'(i);
            shadow[i]    = rng_state ^ word_t'(i);
        end
        for (i = 0; i < NUM_SETS; i++) begin
            tag_m[i] = '0;
        end

        repeat (8) @(posedge CLK);
        #1;
        RSTn = 1'b0;
        @(negedge CLK);
        assert (!resp_valid && !mem_we)
            else abort_run($sformatf("Mismatch at %0t: outputs active after reset", $time));

        run_access(12'h104, 1'b0, '0);              // Cold miss
        run_access(12'h10C, 1'b0, '0);              // Same line, hit
        run_access(12'h108, 1'b1, 32'ha5a5_0001);   // Store hit
        run_access(12'h108, 1'b0, '0);

        // Store miss, then the whole line
        run_access(12'h238, 1'b1, 32'h5a5a_0002);
        run_access(12'h238, 1'b0, '0);
        run_access(12'h230, 1'b0, '0);
        run_access(12'h234, 1'b0, '0);
        run_access(12'h23C, 1'b0, '0);

        // Same index, different tags
        run_access(12'h050, 1'b0, '0);
        run_access(12'h450, 1'b0, '0);
        run_access(12'h050, 1'b0, '0);

        for (i = 0; i < RAND_OPS; i++) begin
            rng_state = lcg_next(rng_state);
            r_addr    = RAND_BASE | addr_t'({rng_state[21:16], 2'b00});
            r_store   = rng_state[27];
            rng_state = lcg_next(rng_state);
            run_access(r_addr, r_store, rng_state);
        end

        // Memory must hold every store
        for (i = 0; i < MEM_WORDS; i++) begin
            assert (u_mem.mem[i] == shadow[i])
                else abort_run($sformatf("Mismatch at %0t: memory word %0d is %h, expected %h",
                                         $time, i, u_mem.mem[i], shadow[i]));
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/word_memory.sv */
`default_nettype none
`timescale 1ns/1ps

module word_memory
    import mem_bus_pkg::*;
(
    input  wire logic  CLK,
    input  wire addr_t addr,       // Byte address
    input  wire logic  we,
    input  wire word_t wdata,
    output word_t      rdata
);

    localparam int DEPTH = 1024;

    word_t      mem [DEPTH];        // Contents loaded at time zero from outside
    logic [9:0] widx;

    assign widx = addr[ADDR_W-1:2];   // Byte select ignored

    // Read in the same cycle
    assign rdata = mem[widx];

    always @(posedge CLK) begin
        if (we) begin
            mem[widx] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`default_nettype none
`timescale 1ns/1ps

module dcache_top
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  wire logic  CLK,
    input  wire logic  RSTn,

    // Requester
    input  wire logic  req,
    input  wire logic  req_store,
    input  wire addr_t req_addr,
    input  wire word_t req_wdata,
    output logic       resp_valid,
    output logic       resp_hit,
    output word_t      resp_rdata,

    // Word memory
    output addr_t      mem_addr,
    output logic       mem_we,
    output word_t      mem_wdata,
    input  wire word_t mem_rdata
);

    //////////////////////////////////////////////////////////////////////
    // Controller to arrays
    //////////////////////////////////////////////////////////////////////

    cache_addr_t look_addr;
    logic        hit;
    word_t       rd_word;
    logic        fill_we;
    word_sel_t   fill_word;
    word_t       fill_data;
    logic        tag_we;

    cache_ctrl u_ctrl (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .req        (req),
        .req_store  (req_store),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_hit   (resp_hit),
        .look_addr  (look_addr),
        .hit        (hit),
        .rd_word    (rd_word),
        .fill_we    (fill_we),
        .fill_word  (fill_word),
        .fill_data  (fill_data),
        .tag_we     (tag_we),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    cache_arrays u_arrays (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .look_addr  (look_addr),
        .hit        (hit),
        .rd_word    (rd_word),
        .fill_we    (fill_we),
        .fill_word  (fill_word),
        .fill_data  (fill_data),
        .tag_we     (tag_we)
    );

endmodule

`default_nettype wire

/* hdl/cache_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module cache_ctrl
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  wire logic      CLK,
    input  wire logic      RSTn,

    // Requester side
    input  wire logic      req,
    input  wire logic      req_store,
    input  wire addr_t     req_addr,
    input  wire word_t     req_wdata,
    output logic           resp_valid,
    output word_t          resp_rdata,
    output logic           resp_hit,

    // Arrays
    output cache_addr_t    look_addr,
    input  wire logic      hit,
    input  wire word_t     rd_word,
    output logic           fill_we,
    output word_sel_t      fill_word,
    output word_t          fill_data,
    output logic           tag_we,

    // Memory side
    output addr_t          mem_addr,
    output logic           mem_we,
    output word_t          mem_wdata,
    input  wire word_t     mem_rdata
);

    // FSM states
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_LOOKUP = 2'd1;
    localparam logic [1:0] ST_REFILL = 2'd2;
    localparam logic [1:0] ST_RESP   = 2'd3;

    logic [1:0]  state;
    word_sel_t   beat;          // Refill word counter

    cache_addr_t cur_addr;      // Captured request
    logic        cur_store;
    word_t       cur_wdata;

    cache_addr_t beat_addr;     // Memory address of current beat
    logic        beat_is_req;
    logic        last_beat;
    logic        in_refill;
    logic        store_hit;
    logic        store_beat;

    //////////////////////////////////////////////////////////////////////
    // Request capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && req) begin
            cur_addr.raw <= req_addr;
            cur_store    <= req_store;
            cur_wdata    <= req_wdata;
        end
    end

    assign look_addr = cur_addr;    // Index and tag stay put for the whole request

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    assign in_refill = (state == ST_REFILL);
    assign last_beat = (beat == word_sel_t'(LINE_WORDS - 1));

    always_ff @(posedge CLK) begin
        if (RSTn) begin
            state <= ST_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    beat  <= '0;
                    state <= hit ? ST_RESP : ST_REFILL;
                end
                ST_REFILL: begin
                    beat <= beat + 2'd1;
                    if (last_beat) begin
                        state <= ST_RESP;
                    end
                end
                default: begin
                    state <= ST_IDLE;   // Response shown for one cycle
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Refill beats and stores
    //////////////////////////////////////////////////////////////////////

    // Line base with the beat as word select
    always_comb begin
        beat_addr        = cur_addr;
        beat_addr.f.word = beat;
        beat_addr.f.bsel = '0;
    end

    assign beat_is_req = (beat == cur_addr.f.word);

    // Write-through on hit, write-allocate on miss
    assign store_hit  = (state == ST_LOOKUP) && cur_store && hit;
    assign store_beat = in_refill && cur_store && beat_is_req;

    assign mem_we    = store_hit || store_beat;
    assign mem_addr  = in_refill ? beat_addr.raw : cur_addr.raw;
    assign mem_wdata = cur_wdata;

    // Store data replaces the memory word on the matching beat
    assign fill_we   = store_hit || in_refill;
    assign fill_word = in_refill ? beat : cur_addr.f.word;
    assign fill_data = mem_we ? cur_wdata : mem_rdata;
    assign tag_we    = in_refill && last_beat;

    //////////////////////////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (state == ST_LOOKUP) begin
            resp_hit   <= hit;
            resp_rdata <= rd_word;      // Final on a hit
        end else if (in_refill && beat_is_req) begin
            resp_rdata <= mem_rdata;    // Requested word as it arrives
        end
    end

    assign resp_valid = (state == ST_RESP);

endmodule

`default_nettype wire

/* hdl/cache_arrays.sv */
`default_nettype none
`timescale 1ns/1ps

module cache_arrays
    import mem_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        RSTn,

    // Lookup
    input  wire cache_addr_t look_addr,
    output logic             hit,
    output word_t            rd_word,

    // Write port
    input  wire logic        fill_we,
    input  wire word_sel_t   fill_word,
    input  wire word_t       fill_data,
    input  wire logic        tag_we
);

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    logic [NUM_LINES-1:0] valid;
    tag_t                 tags  [NUM_LINES];
    word_t                lines [NUM_LINES][LINE_WORDS];

    index_t    idx;         // Line under lookup and write
    tag_t      look_tag;
    word_sel_t look_word;

    assign idx       = look_addr.f.index;
    assign look_tag  = look_addr.f.tag;
    assign look_word = look_addr.f.word;

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    // Hit needs a valid line with a matching tag
    assign hit = valid[idx] && (tags[idx] == look_tag);

    assign rd_word = lines[idx][look_word];     // Read regardless of hit

    //////////////////////////////////////////////////////////////////////
    // Updates
    //////////////////////////////////////////////////////////////////////

    // Valid bits
    always_ff @(posedge CLK) begin
        if (RSTn) begin
            valid <= '0;
        end else if (tag_we) begin
            valid[idx] <= 1'b1;                 // Line complete after last beat
        end
    end

    // Tag written together with the valid bit
    always_ff @(posedge CLK) begin
        if (tag_we) begin
            tags[idx] <= look_tag;
        end
    end

    // One word per cycle, from a refill beat or a store hit
    always_ff @(posedge CLK) begin
        if (fill_we) begin
            lines[idx][fill_word] <= fill_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

    import mem_bus_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Cache organization
    //////////////////////////////////////////////////////////////////////

    // Address fields, top to bottom
    localparam int TAG_W      = 5;
    localparam int INDEX_W    = 3;
    localparam int WORD_SEL_W = 2;
    localparam int BYTE_SEL_W = 2;

    localparam int NUM_LINES  = 2 ** INDEX_W;       // 8 lines
    localparam int LINE_WORDS = 2 ** WORD_SEL_W;    // 4 words per line

    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

    //////////////////////////////////////////////////////////////////////
    // Address word, raw or split into fields
    //////////////////////////////////////////////////////////////////////

    typedef union packed {
        addr_t raw;                         // Plain byte address
        struct packed {
            tag_t                  tag;
            index_t                index;
            word_sel_t             word;    // Word within line
            logic [BYTE_SEL_W-1:0] bsel;    // Byte within word
        } f;
    } cache_addr_t;

endpackage

`default_nettype wire

/* hdl/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // Request and memory bus widths
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W = 12;     // Byte address
    localparam int DATA_W = 32;     // Whole words only

    // Byte address as seen by requester and memory
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word
    typedef logic [DATA_W-1:0] word_t;

endpackage

`default_nettype wire
